// File: outputArbiter.f
verilog/routerPkg.sv
verilog/flitIf.sv
verilog/portTimer.sv
verilog/grantFsm.sv
verilog/flitSwitch.sv
verilog/outputArbiter.sv
tb/outputArbiter_asserts.sv
tb/outputArbiterChecker.sv
tb/outputArbiterTb.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it into sim.log and looks for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module outputArbiterTb -f outputArbiter.f -o simv \
  && ./obj_dir/simv > sim.log 2>&1 || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

// File: tb/outputArbiter_cases.txt
# packet: 0 test port start length gap seed (ports 0 L, 1 N, 2 E, 3 W, 4 S)
# stall:  1 test 0 firstCycle lastCycle 0 0 (outReady low in that window)
0 1 0 5 4 0 11
0 1 2 40 1 0 12
0 1 4 60 3 1 13
0 2 1 100 5 1 21
0 2 3 102 4 0 22
0 2 0 103 3 2 23
0 3 0 150 3 0 31
0 3 1 150 3 0 32
0 3 2 150 3 0 33
0 3 3 150 3 0 34
0 3 4 150 3 0 35
0 3 0 164 2 0 36
0 3 1 164 2 0 37
0 3 2 164 2 0 38
0 3 3 164 2 0 39
0 3 4 164 2 0 40
0 4 2 195 6 0 41
0 4 1 198 4 0 42
1 4 0 200 230 0 0
0 4 0 238 5 1 43
1 4 0 240 245 0 0
0 5 3 270 4 5 51
0 5 4 275 4 1 52
0 5 2 280 3 2 53
0 5 3 300 3 0 54

// File: tb/outputArbiterTb.sv
`timescale 1ns/1ps

module outputArbiterTb import routerPkg::*; ();

  logic clk = 0;
  logic rst = 1;
  logic outReady = 0;
  logic runEnded = 0;
  logic vIn [NumPorts];
  flitData dIn [NumPorts];
  flitKind kIn [NumPorts];
  logic [NumPorts-1:0] readyVec;
  logic outValid, abortValid, allDone;
  flitData outData;
  flitKind outKind;
  portIdx outPort, abortPort;
  int errors;
  int cycle = 0;
  int limit = 200;
  int nP = 0, nS = 0;
  int pPort [64], pStart [64], pLen [64], pGap [64], pSeed [64];
  int sFirst [16], sLast [16];

  always #10 clk = ~clk;

  outputArbiter #(.TimeoutSlack(8)) DUT (
    .clk, .rst,
    .localValid(vIn[0]), .localReady(readyVec[0]), .localData(dIn[0]), .localKind(kIn[0]),
    .northValid(vIn[1]), .northReady(readyVec[1]), .northData(dIn[1]), .northKind(kIn[1]),
    .eastValid(vIn[2]), .eastReady(readyVec[2]), .eastData(dIn[2]), .eastKind(kIn[2]),
    .westValid(vIn[3]), .westReady(readyVec[3]), .westData(dIn[3]), .westKind(kIn[3]),
    .southValid(vIn[4]), .southReady(readyVec[4]), .southData(dIn[4]), .southKind(kIn[4]),
    .outValid, .outReady, .outData, .outKind, .outPort, .abortValid, .abortPort
  );

  outputArbiterChecker #(.TimeoutSlack(8)) chk (
    .clk, .rst, .outValid, .outReady, .outData, .outKind, .outPort,
    .abortValid, .abortPort, .runEnded, .allDone, .errors
  );

  always @(posedge clk)
    cycle <= rst ? 0 : cycle + 1;

  // output stalls follow the windows of the case file
  always @(posedge clk)
  begin
    bit stall;
    #2;
    stall = 0;
    for (int i = 0; i < nS; i++)
      if (cycle >= sFirst[i] && cycle <= sLast[i])
        stall = 1;
    outReady = !rst && !stall;
  end

  task automatic drivePort(input int p);
    int seed, r;
    bit taken;
    for (int k = 0; k < nP; k++)
    begin
      if (pPort[k] != p)
        continue;
      seed = 29500 + pSeed[k];
      while (cycle < pStart[k])
      begin
        @(posedge clk);
        #2;
      end
      for (int f = 0; f < pLen[k]; f++)
      begin
        if (f > 0)
          repeat (pGap[k])
          begin
            @(posedge clk);
            #2;
          end
        r = $random(seed);
        dIn[p] = (f == 0) ? {r[15:12], pLen[k][11:0]} : r[15:0];
        kIn[p] = (f == 0) ? KindHead : ((f == pLen[k] - 1) ? KindTail : KindBody);
        vIn[p] = 1;
        do
        begin
          @(negedge clk);
          taken = readyVec[p];
          @(posedge clk);
          #2;
        end while (!taken);
        vIn[p] = 0;
      end
    end
  endtask

  initial
  begin
    int fd, ty, t, p, s, l, g, sd;
    string line;
    for (int i = 0; i < NumPorts; i++)
    begin
      vIn[i] = 0;
      dIn[i] = '0;
      kIn[i] = '0;
    end
    fd = $fopen("tb/outputArbiter_cases.txt", "r");
    while ($fgets(line, fd))
    begin
      if ($sscanf(line, "%d %d %d %d %d %d %d", ty, t, p, s, l, g, sd) != 7)
        continue;
      if (ty == 1)
      begin
        sFirst[nS] = s;
        sLast[nS] = l;
        limit += l - s + 1;
        nS++;
      end
      else
      begin
        {pPort[nP], pStart[nP], pLen[nP], pGap[nP], pSeed[nP]} = {p, s, l, g, sd};
        limit += s + l * (g + 1);
        nP++;
      end
    end
    $fclose(fd);
    repeat (4) @(posedge clk);
    #2;
    rst = 0;
    for (int i = 0; i < NumPorts; i++)
    begin
      automatic int q = i;
      fork
        drivePort(q);
      join_none
    end
    while (!allDone && cycle < limit)
      @(posedge clk);
    runEnded = 1;
    repeat (2) @(negedge clk);
    if (!allDone)
      $display("run stopped after %0d cycles with packets still outstanding", cycle);
    if (!allDone || errors != 0)
      $display("Test failed");
    else
      $display("Test passed");
    $finish;
  end

endmodule

// File: tb/outputArbiterChecker.sv
`timescale 1ns/1ps

module outputArbiterChecker import routerPkg::*; #(
  parameter int TimeoutSlack = 8
) (
  input logic clk,
  input logic rst,
  input logic outValid,
  input logic outReady,
  input flitData outData,
  input flitKind outKind,
  input portIdx outPort,
  input logic abortValid,
  input portIdx abortPort,
  input logic runEnded,
  output logic allDone,
  output int errors
);

  int pTest [64], pPort [64], pStart [64], pLen [64];
  bit pAbort [64], pHeaded [64], pDone [64];
  flitData eData [NumPorts][256];
  flitKind eKind [NumPorts][256];
  int ePkt [NumPorts][256];
  int wr [NumPorts], rd [NumPorts];
  int numPkts = 0, doneCount = 0, flits = 0, aborts = 0, openPort = -1;
  bit reported = 0;

  assign allDone = (numPkts > 0) && (doneCount == numPkts);

  initial
  begin
    int fd, ty, t, p, s, l, g, sd, seed, r;
    string line;
    errors = 0;
    for (int i = 0; i < NumPorts; i++)
    begin
      wr[i] = 0;
      rd[i] = 0;
    end
    fd = $fopen("tb/outputArbiter_cases.txt", "r");
    while ($fgets(line, fd))
    begin
      if ($sscanf(line, "%d %d %d %d %d %d %d", ty, t, p, s, l, g, sd) != 7 || ty != 0)
        continue;
      pTest[numPkts] = t;
      pPort[numPkts] = p;
      pStart[numPkts] = s;
      pLen[numPkts] = l;
      // a budget of length plus slack is lost once the gaps exceed the slack
      pAbort[numPkts] = ((l - 1) * g) > TimeoutSlack;
      seed = 29500 + sd;
      for (int f = 0; f < l; f++)
      begin
        r = $random(seed);
        eData[p][wr[p]] = (f == 0) ? {r[15:12], l[11:0]} : r[15:0];
        eKind[p][wr[p]] = (f == 0) ? KindHead : ((f == l - 1) ? KindTail : KindBody);
        ePkt[p][wr[p]] = numPkts;
        wr[p]++;
      end
      numPkts++;
    end
    $fclose(fd);
  end

  task automatic markDone(input int k);
    bit whole;
    pDone[k] = 1;
    doneCount++;
    whole = 1;
    for (int j = 0; j < numPkts; j++)
      if (pTest[j] == pTest[k] && !pDone[j])
        whole = 0;
    if (whole)
      $display("test %0d finished, %0d errors so far", pTest[k], errors);
  endtask

  task automatic takeFlit(input int p);
    int k;
    if (rd[p] >= wr[p])
    begin
      $display("port %0d sent a flit at %0t although nothing was expected", p, $time);
      errors++;
      return;
    end
    k = ePkt[p][rd[p]];
    flits++;
    if (outData !== eData[p][rd[p]] || outKind !== eKind[p][rd[p]])
    begin
      $display("FAILED %0t outData/outKind port %0d expected %h/%0d got %h/%0d", $time, p,
               eData[p][rd[p]], eKind[p][rd[p]], outData, outKind);
      errors++;
    end
    if (openPort >= 0 && openPort != p)
    begin
      $display("port %0d cut into the open packet of port %0d at %0t", p, openPort, $time);
      errors++;
    end
    if (outKind == KindHead)
    begin
      // ports that asked in the same cycle are served from Local upwards
      for (int j = 0; j < numPkts; j++)
        if (pTest[j] == pTest[k] && pStart[j] == pStart[k] && pPort[j] < p && !pHeaded[j])
        begin
          $display("port %0d won at %0t ahead of waiting port %0d", p, $time, pPort[j]);
          errors++;
        end
      pHeaded[k] = 1;
    end
    rd[p]++;
    openPort = p;
    if (rd[p] == wr[p] || ePkt[p][rd[p]] != k)
    begin
      openPort = -1;
      if (pAbort[k])
      begin
        $display("packet %0d of port %0d finished without the expected abort", k, p);
        errors++;
      end
      markDone(k);
    end
  endtask

  always @(negedge clk)
  begin
    int k;
    if (!rst && outValid && outReady)
      takeFlit(outPort);
    if (!rst && abortValid)
    begin
      k = (rd[abortPort] < wr[abortPort]) ? ePkt[abortPort][rd[abortPort]] : -1;
      if (k < 0 || !pAbort[k])
      begin
        $display("unexpected abort on port %0d at %0t", abortPort, $time);
        errors++;
      end
      else
      begin
        while (rd[abortPort] < wr[abortPort] && ePkt[abortPort][rd[abortPort]] == k)
          rd[abortPort]++;
        aborts++;
        openPort = -1;
        markDone(k);
      end
    end
  end

  always @(posedge clk)
  begin
    if (runEnded && !reported)
    begin
      reported = 1;
      for (int p = 0; p < NumPorts; p++)
        if (rd[p] < wr[p])
        begin
          $display("port %0d still has %0d flits that never arrived", p, wr[p] - rd[p]);
          errors++;
        end
      $display("checked %0d flits, %0d aborts, %0d of %0d packets done, %0d errors",
               flits, aborts, doneCount, numPkts, errors);
    end
  end

endmodule

// File: tb/outputArbiter_asserts.sv
`timescale 1ns/1ps

module outputArbiterAsserts import routerPkg::*; (
  input logic clk,
  input logic rst,
  input grantState state,
  input logic [NumPorts-1:0] pending,
  input logic grantActive,
  input logic abortValid,
  input logic outReady
);

  // a head waiting while the FSM is idle is granted on the next edge, and none keeps it idle
  idleGrantFollowsRequest: assert property (@(posedge clk) disable iff (rst)
    (state == Idle) |=> (grantActive == $past(|pending)))
    else $error("grant out of Idle did not follow the waiting requests");

  abortOneCycle: assert property (@(posedge clk) disable iff (rst)
    abortValid |=> !abortValid)
    else $error("abortValid held for more than one cycle");

  // a stalled output cannot finish a tail, so only an abort may move the grant
  grantHeldInStall: assert property (@(posedge clk) disable iff (rst)
    (grantActive && !outReady && !abortValid) |=> (state == $past(state)))
    else $error("grant moved while the output was stalled");

endmodule

bind grantFsm outputArbiterAsserts grantChecks (
  .clk(clk),
  .rst(rst),
  .state(state),
  .pending(pending),
  .grantActive(grantActive),
  .abortValid(abortValid),
  .outReady(outReady)
);

// File: verilog/outputArbiter.sv
`timescale 1ns/1ps

module outputArbiter import routerPkg::*; #(
  parameter int TimeoutSlack = 8
) (
  input logic clk,
  input logic rst,
  input logic localValid,
  output logic localReady,
  input flitData localData,
  input flitKind localKind,
  input logic northValid,
  output logic northReady,
  input flitData northData,
  input flitKind northKind,
  input logic eastValid,
  output logic eastReady,
  input flitData eastData,
  input flitKind eastKind,
  input logic westValid,
  output logic westReady,
  input flitData westData,
  input flitKind westKind,
  input logic southValid,
  output logic southReady,
  input flitData southData,
  input flitKind southKind,
  output logic outValid,
  input logic outReady,
  output flitData outData,
  output flitKind outKind,
  output portIdx outPort,
  output logic abortValid,
  output portIdx abortPort
);

  logic [NumPorts-1:0] timesUp;
  logic [NumPorts-1:0] runTimer;
  portIdx grantPort;
  logic grantActive;
  logic tailSent;

  flitIf localFlit ();
  flitIf northFlit ();
  flitIf eastFlit ();
  flitIf westFlit ();
  flitIf southFlit ();

  assign {localFlit.valid, localFlit.data, localFlit.kind} = {localValid, localData, localKind};
  assign {northFlit.valid, northFlit.data, northFlit.kind} = {northValid, northData, northKind};
  assign {eastFlit.valid, eastFlit.data, eastFlit.kind} = {eastValid, eastData, eastKind};
  assign {westFlit.valid, westFlit.data, westFlit.kind} = {westValid, westData, westKind};
  assign {southFlit.valid, southFlit.data, southFlit.kind} = {southValid, southData, southKind};

  assign localReady = localFlit.ready;
  assign northReady = northFlit.ready;
  assign eastReady = eastFlit.ready;
  assign westReady = westFlit.ready;
  assign southReady = southFlit.ready;

  portTimer #(.TimeoutSlack(TimeoutSlack)) timerLocal (
    .clk, .rst, .flit(localFlit), .runTimer(runTimer[PortLocal]), .timesUp(timesUp[PortLocal])
  );
  portTimer #(.TimeoutSlack(TimeoutSlack)) timerNorth (
    .clk, .rst, .flit(northFlit), .runTimer(runTimer[PortNorth]), .timesUp(timesUp[PortNorth])
  );
  portTimer #(.TimeoutSlack(TimeoutSlack)) timerEast (
    .clk, .rst, .flit(eastFlit), .runTimer(runTimer[PortEast]), .timesUp(timesUp[PortEast])
  );
  portTimer #(.TimeoutSlack(TimeoutSlack)) timerWest (
    .clk, .rst, .flit(westFlit), .runTimer(runTimer[PortWest]), .timesUp(timesUp[PortWest])
  );
  portTimer #(.TimeoutSlack(TimeoutSlack)) timerSouth (
    .clk, .rst, .flit(southFlit), .runTimer(runTimer[PortSouth]), .timesUp(timesUp[PortSouth])
  );

  grantFsm fsm (
    .clk,
    .rst,
    .localPort(localFlit),
    .northPort(northFlit),
    .eastPort(eastFlit),
    .westPort(westFlit),
    .southPort(southFlit),
    .timesUp,
    .tailSent,
    .outReady,
    .grantPort,
    .grantActive,
    .runTimer,
    .abortValid,
    .abortPort
  );

  flitSwitch switch (
    .clk,
    .rst,
    .localPort(localFlit),
    .northPort(northFlit),
    .eastPort(eastFlit),
    .westPort(westFlit),
    .southPort(southFlit),
    .grantPort,
    .grantActive,
    .abortValid,
    .abortPort,
    .outValid,
    .outReady,
    .outData,
    .outKind,
    .outPort,
    .tailSent
  );

endmodule

// File: verilog/flitSwitch.sv
`timescale 1ns/1ps

module flitSwitch import routerPkg::*; (
  input logic clk,
  input logic rst,
  flitIf.sink localPort,
  flitIf.sink northPort,
  flitIf.sink eastPort,
  flitIf.sink westPort,
  flitIf.sink southPort,
  input portIdx grantPort,
  input logic grantActive,
  input logic abortValid,
  input portIdx abortPort,
  output logic outValid,
  input logic outReady,
  output flitData outData,
  output flitKind outKind,
  output portIdx outPort,
  output logic tailSent
);

  logic [NumPorts-1:0] inValid;
  flitData inData [NumPorts];
  flitKind inKind [NumPorts];
  logic [NumPorts-1:0] inReady;
  logic [NumPorts-1:0] inTail;
  logic [NumPorts-1:0] pending;
  logic [NumPorts-1:0] drain;
  logic [NumPorts-1:0] drainNow;
  logic [NumPorts-1:0] drainDone;

  assign inValid = {southPort.valid, westPort.valid, eastPort.valid,
                    northPort.valid, localPort.valid};
  assign inData = '{localPort.data, northPort.data, eastPort.data, westPort.data, southPort.data};
  assign inKind = '{localPort.kind, northPort.kind, eastPort.kind, westPort.kind, southPort.kind};

  assign {southPort.ready, westPort.ready, eastPort.ready,
          northPort.ready, localPort.ready} = inReady;
  assign {southPort.reqPending, westPort.reqPending, eastPort.reqPending,
          northPort.reqPending, localPort.reqPending} = pending;

  // an aborted port starts swallowing flits in the abort cycle itself
  always_comb
  begin
    for (int i = 0; i < NumPorts; i++)
    begin
      inTail[i] = isTail(inKind[i], inData[i]);
      drainNow[i] = drain[i] || (abortValid && (abortPort == portIdx'(i)));
      inReady[i] = drainNow[i] || (grantActive && (grantPort == portIdx'(i)) && outReady);
      pending[i] = inValid[i] && (inKind[i] == KindHead) && !drainNow[i];
      drainDone[i] = drainNow[i] && inValid[i] && inTail[i];
    end
  end

  assign outValid = grantActive && inValid[grantPort];
  assign outData = inData[grantPort];
  assign outKind = inKind[grantPort];
  assign outPort = grantPort;
  assign tailSent = outValid && outReady && inTail[grantPort];

  always_ff @(posedge clk)
  begin
    if (rst)
      drain <= '0;
    else
      drain <= drainNow & ~drainDone;
  end

endmodule

// File: verilog/grantFsm.sv
`timescale 1ns/1ps

module grantFsm import routerPkg::*; (
  input logic clk,
  input logic rst,
  flitIf.monitor localPort,
  flitIf.monitor northPort,
  flitIf.monitor eastPort,
  flitIf.monitor westPort,
  flitIf.monitor southPort,
  input logic [NumPorts-1:0] timesUp,
  input logic tailSent,
  input logic outReady,
  output portIdx grantPort,
  output logic grantActive,
  output logic [NumPorts-1:0] runTimer,
  output logic abortValid,
  output portIdx abortPort
);

  grantState state;
  grantState nextState;
  logic [NumPorts-1:0] pending;
  logic [NumPorts-1:0] accepted;
  logic [NumPorts-1:0] req;
  logic expire;
  portIdx rotateStart;

  // first requester found when walking the ports from first onwards
  function automatic grantState pickNext(logic [NumPorts-1:0] reqs, portIdx first);
    grantState pick;
    portIdx idx;
    pick = Idle;
    for (int k = NumPorts - 1; k >= 0; k--)
    begin
      idx = portIdx'((int'(first) + k) % NumPorts);
      if (reqs[idx])
        pick = grantState'(idx + 3'd1);
    end
    return pick;
  endfunction

  assign pending = {southPort.reqPending, westPort.reqPending, eastPort.reqPending,
                    northPort.reqPending, localPort.reqPending};
  assign accepted = {southPort.valid && southPort.ready, westPort.valid && westPort.ready,
                     eastPort.valid && eastPort.ready, northPort.valid && northPort.ready,
                     localPort.valid && localPort.ready};

  // a head taken this cycle is no longer a request for the next grant
  assign req = pending & ~accepted;

  assign grantPort = (state == Idle) ? PortLocal : portIdx'(state - 3'd1);

  // an expired budget takes the grant away in the same cycle it is seen
  assign expire = (state != Idle) && timesUp[grantPort];
  assign grantActive = (state != Idle) && !expire;

  assign abortValid = expire;
  assign abortPort = grantPort;

  always_comb
  begin
    runTimer = '0;
    if (grantActive && outReady)
      runTimer[grantPort] = 1'b1;
  end

  assign rotateStart = (grantPort == PortSouth) ? PortLocal : grantPort + 3'd1;

  always_comb
  begin
    nextState = state;
    if (state == Idle)
      nextState = pickNext(req, PortLocal);
    else if (tailSent || expire)
      nextState = pickNext(req, rotateStart);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= Idle;
    else
      state <= nextState;
  end

endmodule

// File: verilog/portTimer.sv
`timescale 1ns/1ps

module portTimer import routerPkg::*; #(
  parameter int TimeoutSlack = 8
) (
  input logic clk,
  input logic rst,
  flitIf.monitor flit,
  input logic runTimer,
  output logic timesUp
);

  pktLength budget;
  pktLength count;
  logic headTaken;

  assign headTaken = flit.valid && flit.ready && (flit.kind == KindHead);

  // a zero count means no packet is being timed
  assign timesUp = (count != '0) && (count == budget);

  always_ff @(posedge clk)
  begin
    if (headTaken)
      budget <= flit.data[LenWidth-1:0] + pktLength'(TimeoutSlack);
  end

  // the count holds while the output stalls and restarts with every head,
  // which also counts the cycle in which the head itself goes out
  always_ff @(posedge clk)
  begin
    if (rst)
      count <= '0;
    else if (headTaken)
      count <= pktLength'(runTimer);
    else if (timesUp)
      count <= '0;
    else if (runTimer)
      count <= count + pktLength'(1);
  end

endmodule

// File: verilog/flitIf.sv
`timescale 1ns/1ps

interface flitIf import routerPkg::*; ();

  logic valid;
  logic ready;
  flitData data;
  flitKind kind;
  // a head is waiting at this port and the port is not draining
  logic reqPending;

  modport source (
    output valid, data, kind,
    input ready, reqPending
  );

  modport sink (
    input valid, data, kind,
    output ready, reqPending
  );

  modport monitor (
    input valid, ready, data, kind, reqPending
  );

endinterface

// File: verilog/routerPkg.sv
package routerPkg;

  localparam int FlitWidth = 16;
  localparam int LenWidth = 12;
  localparam int NumPorts = 5;

  typedef logic [FlitWidth-1:0] flitData;
  typedef logic [1:0] flitKind;
  typedef logic [LenWidth-1:0] pktLength;
  typedef logic [2:0] portIdx;

  localparam flitKind KindHead = 2'd1;
  localparam flitKind KindBody = 2'd2;
  localparam flitKind KindTail = 2'd3;

  localparam portIdx PortLocal = 3'd0;
  localparam portIdx PortNorth = 3'd1;
  localparam portIdx PortEast = 3'd2;
  localparam portIdx PortWest = 3'd3;
  localparam portIdx PortSouth = 3'd4;

  // grant states are one past the port index they serve
  typedef enum logic [2:0] {
    Idle = 3'd0,
    GrantLocal = 3'd1,
    GrantNorth = 3'd2,
    GrantEast = 3'd3,
    GrantWest = 3'd4,
    GrantSouth = 3'd5
  } grantState;

  // a head of length 1 is a whole packet and closes itself
  function automatic logic isTail(flitKind kind, flitData data);
    return (kind == KindTail) ||
           ((kind == KindHead) && (data[LenWidth-1:0] == pktLength'(1)));
  endfunction

endpackage
